// ==== hdl/alu16_defines.svh ====
`ifndef ALU16_DEFINES_SVH
`define ALU16_DEFINES_SVH

// ##############################
// datapath widths
// ##############################
`define ALU16_WIDTH 16 // operand width in bits.
`define ALU16_IDX_W 4  // enough to address every operand bit.
`define ALU16_OP_W  3  // eight operations.

// ##############################
// latency
// ##############################
`define ALU16_DONE_LATENCY 18 // edges from the start sample up to done including the sample edge.

`endif

// ==== hdl/alu16_pkg.sv ====
`include "alu16_defines.svh"

package alu16_pkg;

    // ##############################
    // vector types
    // ##############################
    typedef logic [`ALU16_WIDTH-1:0] word_t;    // one operand.
    typedef logic [`ALU16_WIDTH:0]   result_t;  // result with the carry on top.
    typedef logic [`ALU16_IDX_W-1:0] bit_idx_t; // position of the bit in flight.

    // ##############################
    // enums
    // ##############################
    typedef enum logic [`ALU16_OP_W-1:0] {
        OP_ADD  = 3'b000,
        OP_SUB  = 3'b001,
        OP_XOR  = 3'b010,
        OP_AND  = 3'b011,
        OP_NOT  = 3'b100, // works on a only.
        OP_OR   = 3'b101,
        OP_NOR  = 3'b110,
        OP_NAND = 3'b111
    } alu_op_e;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_RUN  = 1'b1
    } load_state_e;

    // ##############################
    // serial steps
    // ##############################
    typedef struct packed {
        logic     valid;
        logic     first; // high on index 0 only.
        logic     a_bit;
        logic     b_bit;
        alu_op_e  op;
        bit_idx_t idx;
    } bit_pair_s;

    typedef struct packed {
        logic     valid;
        logic     r_bit;
        logic     carry; // carry register after this step.
        bit_idx_t idx;   // all ones marks the last step.
    } result_bit_s;

endpackage

// ==== hdl/operand_loader.sv ====
`include "alu16_defines.svh"

module operand_loader
    import alu16_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      start,
    input  word_t     a,
    input  word_t     b,
    input  alu_op_e   op,
    output logic      busy,
    output bit_pair_s bits
);

    load_state_e state_q;
    bit_idx_t    idx_q;
    word_t       a_q;
    word_t       b_q;
    alu_op_e     op_q;
    logic        accept;
    logic        last_idx;

    assign accept   = start && (state_q == ST_IDLE); // a start while running is dropped.
    assign last_idx = (idx_q == bit_idx_t'(`ALU16_WIDTH - 1));

    // ##############################
    // sequencer
    // ##############################
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ST_IDLE;
            idx_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q <= ST_RUN;
                        idx_q   <= '0;
                    end
                end
                ST_RUN: begin
                    idx_q <= idx_q + 1'b1; // wraps back to zero after the last bit.
                    if (last_idx) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // ##############################
    // operand capture
    // ##############################
    always_ff @(posedge clk) begin
        if (accept) begin
            a_q  <= a;
            b_q  <= b;
            op_q <= op;
        end
    end

    // the counter selects one bit of each operand starting at the lsb.
    always_comb begin
        bits.valid = (state_q == ST_RUN);
        bits.first = (state_q == ST_RUN) && (idx_q == '0);
        bits.a_bit = a_q[idx_q];
        bits.b_bit = b_q[idx_q];
        bits.op    = op_q;
        bits.idx   = idx_q;
    end

    assign busy = (state_q == ST_RUN);

endmodule

// ==== hdl/serial_alu.sv ====
module serial_alu
    import alu16_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  bit_pair_s   bits,
    output result_bit_s rbits
);

    logic     carry_q;
    logic     valid_q;
    logic     r_bit_q;
    bit_idx_t idx_q;

    logic     is_arith;
    logic     is_sub;
    logic     b_eff;
    logic     cin;
    logic     sum;
    logic     cout;
    logic     r_bit_d;

    // ##############################
    // bitwise operations
    // ##############################
    function automatic logic logic_bit(input alu_op_e op, input logic a, input logic b);
        logic y;
        case (op)
            OP_XOR:  y = a ^ b;
            OP_AND:  y = a & b;
            OP_NOT:  y = ~a;
            OP_OR:   y = a | b;
            OP_NOR:  y = ~(a | b);
            OP_NAND: y = ~(a & b);
            default: y = 1'b0; // add and sub go through the adder.
        endcase
        return y;
    endfunction

    // ##############################
    // full adder slice
    // ##############################
    assign is_sub   = (bits.op == OP_SUB);
    assign is_arith = (bits.op == OP_ADD) || is_sub;

    always_comb begin
        b_eff = bits.b_bit ^ is_sub;               // sub adds the inverted b.
        cin   = bits.first ? is_sub : carry_q;     // sub starts with a carry of one.
        sum   = bits.a_bit ^ b_eff ^ cin;
        cout  = (bits.a_bit & b_eff) | (cin & (bits.a_bit ^ b_eff));
        if (is_arith) begin
            r_bit_d = sum;
        end else begin
            r_bit_d = logic_bit(bits.op, bits.a_bit, bits.b_bit);
        end
    end

    // ##############################
    // carry and output registers
    // ##############################
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
            carry_q <= 1'b0;
        end else begin
            valid_q <= bits.valid;
            if (bits.valid) begin
                carry_q <= is_arith ? cout : 1'b0; // logic operations leave no carry.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bits.valid) begin
            r_bit_q <= r_bit_d;
            idx_q   <= bits.idx;
        end
    end

    always_comb begin
        rbits.valid = valid_q;
        rbits.r_bit = r_bit_q;
        rbits.carry = carry_q;
        rbits.idx   = idx_q;
    end

endmodule

// ==== hdl/result_collector.sv ====
`include "alu16_defines.svh"

module result_collector
    import alu16_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  result_bit_s rbits,
    output result_t     result,
    output logic        done
);

    word_t   shadow_q;
    word_t   final_word;
    result_t result_q;
    logic    done_q;
    logic    last_step;

    assign last_step = rbits.valid && (rbits.idx == '1);

    // ##############################
    // bit deposit
    // ##############################
    always_ff @(posedge clk) begin
        if (rbits.valid) begin
            shadow_q[rbits.idx] <= rbits.r_bit; // each step lands in its own position.
        end
    end

    // the top bit arrives with the last step and bypasses the shadow word.
    assign final_word = {rbits.r_bit, shadow_q[`ALU16_WIDTH-2:0]};

    // ##############################
    // finished word
    // ##############################
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_q <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= last_step;
            if (last_step) begin
                result_q <= {rbits.carry, final_word}; // held until the next done.
            end
        end
    end

    assign result = result_q;
    assign done   = done_q;

endmodule

// ==== hdl/alu16_top.sv ====
module alu16_top
    import alu16_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    start,
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    output logic    busy,
    output logic    done,
    output result_t result
);

    bit_pair_s   bits;
    result_bit_s rbits;

    operand_loader i_operand_loader (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .a      (a),
        .b      (b),
        .op     (op),
        .busy   (busy),
        .bits   (bits)
    );

    serial_alu i_serial_alu (
        .clk    (clk),
        .arst_n (arst_n),
        .bits   (bits),
        .rbits  (rbits)
    );

    result_collector i_result_collector (
        .clk    (clk),
        .arst_n (arst_n),
        .rbits  (rbits),
        .result (result),
        .done   (done)
    );

endmodule

// ==== testbench/alu16_sva.sv ====
`include "alu16_defines.svh"

module alu16_sva
    import alu16_pkg::*;
(
    input logic    clk,
    input logic    arst_n,
    input logic    start,
    input word_t   a,
    input word_t   b,
    input alu_op_e op,
    input logic    busy,
    input logic    done,
    input result_t result
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DONE_LAT = `ALU16_DONE_LATENCY;

    int         fail_count = 0;
    logic       accepted;
    logic       started_q;
    result_t    exp_q [2];
    result_t    exp_head;
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] pending_q;
    logic [4:0] busy_age_q;

    // the 17-bit result that each operation should produce.
    function automatic result_t model_result(input alu_op_e f, input word_t x, input word_t y);
        result_t r;
        case (f)
            OP_ADD:  r = {1'b0, x} + {1'b0, y};
            OP_SUB:  r = {1'b0, x} + {1'b0, ~y} + 17'd1;
            OP_XOR:  r = {1'b0, x ^ y};
            OP_AND:  r = {1'b0, x & y};
            OP_NOT:  r = {1'b0, ~x};
            OP_OR:   r = {1'b0, x | y};
            OP_NOR:  r = {1'b0, ~(x | y)};
            default: r = {1'b0, ~(x & y)};
        endcase
        return r;
    endfunction

    assign accepted = start && !busy;
    assign exp_head = exp_q[rd_ptr_q];

    // two slots are kept because a new start may be accepted one cycle before done.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            started_q  <= 1'b0;
            exp_q[0]   <= '0;
            exp_q[1]   <= '0;
            wr_ptr_q   <= 1'b0;
            rd_ptr_q   <= 1'b0;
            pending_q  <= 2'd0;
            busy_age_q <= 5'd0;
        end else begin
            if (accepted) begin
                started_q       <= 1'b1;
                exp_q[wr_ptr_q] <= model_result(op, a, b);
                wr_ptr_q        <= ~wr_ptr_q;
            end
            if (done) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            if (accepted && !done) begin
                pending_q <= pending_q + 2'd1;
            end else if (!accepted && done && pending_q != 2'd0) begin
                pending_q <= pending_q - 2'd1;
            end
            busy_age_q <= busy ? busy_age_q + 5'd1 : 5'd0; // consecutive busy cycles.
        end
    end

    // ##############################
    // properties
    // ##############################
    a_reset_state: assert property (@(posedge clk) disable iff (!arst_n)
        !started_q |-> (!busy && !done && result == '0))
        else begin
            fail_count++;
            $error("[FAIL] busy %h done %h result %h expected all zero before the first start",
                $sampled(busy), $sampled(done), $sampled(result));
        end

    a_busy_rise: assert property (@(posedge clk) disable iff (!arst_n) accepted |=> busy)
        else begin
            fail_count++;
            $error("[FAIL] busy expected 1 actual 0 after an accepted start");
        end

    a_busy_len: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(busy) |-> busy_age_q == 5'd16)
        else begin
            fail_count++;
            $error("[FAIL] busy_age expected 10 actual %h when busy fell", $sampled(busy_age_q));
        end

    a_done_time: assert property (@(posedge clk) disable iff (!arst_n)
        accepted |-> ##DONE_LAT done)
        else begin
            fail_count++;
            $error("[FAIL] done expected 1 actual 0 at the fixed latency after start");
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
        else begin
            fail_count++;
            $error("[FAIL] done expected 0 actual 1 in the cycle after done");
        end

    a_done_owed: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> pending_q != 2'd0)
        else begin
            fail_count++;
            $error("[FAIL] done arrived with no accepted start outstanding");
        end

    a_done_value: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> result == exp_head)
        else begin
            fail_count++;
            $error("[FAIL] result expected %h actual %h", $sampled(exp_head), $sampled(result));
        end

endmodule

bind alu16_top alu16_sva i_alu16_sva (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (start),
    .a      (a),
    .b      (b),
    .op     (op),
    .busy   (busy),
    .done   (done),
    .result (result)
);

// ==== testbench/alu16_tb.sv ====
module alu16_tb
    import alu16_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 40;

    logic    clk;
    logic    arst_n;
    logic    start;
    word_t   a;
    word_t   b;
    alu_op_e op;
    logic    busy;
    logic    done;
    result_t result;
    int      errors;
    int      total;
    integer  seed;
    alu_op_e logic_ops [6] = '{OP_XOR, OP_AND, OP_NOT, OP_OR, OP_NOR, OP_NAND};

    alu16_top i_alu16_top (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .a      (a),
        .b      (b),
        .op     (op),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    always #20 clk = ~clk;

    function automatic word_t rand_word();
        return word_t'($random(seed));
    endfunction

    // ##############################
    // stimulus tasks
    // ##############################
    task automatic start_op(input alu_op_e f, input word_t x, input word_t y);
        @(posedge clk);
        #2;
        start = 1'b1;
        op    = f;
        a     = x;
        b     = y;
        @(posedge clk);
        #2;
        start = 1'b0;
        a     = rand_word(); // operands only count in the start cycle.
        b     = rand_word();
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            errors++;
            $display("timeout: busy still high after %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic wait_done();
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge clk);
            seen = done;
            n++;
        end
        if (!seen) begin
            errors++;
            $display("timeout: no done within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic run_op(input alu_op_e f, input word_t x, input word_t y);
        wait_idle();
        start_op(f, x, y);
        wait_done();
    endtask

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        start  = 1'b0;
        a      = '0;
        b      = '0;
        op     = OP_ADD;
        errors = 0;
        seed   = 42;
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;
        repeat (3) @(posedge clk); // idle stretch for the reset state check.

        run_op(OP_ADD, 16'hFFFF, 16'h0001);
        for (int i = 0; i < 6; i++) begin
            run_op(OP_ADD, rand_word(), rand_word());
        end
        run_op(OP_SUB, 16'h1234, 16'h1234);
        run_op(OP_SUB, 16'h0010, 16'h0020);
        for (int i = 0; i < 6; i++) begin
            run_op(OP_SUB, rand_word(), rand_word());
        end
        foreach (logic_ops[k]) begin
            for (int i = 0; i < 3; i++) begin
                run_op(logic_ops[k], rand_word(), rand_word());
            end
        end

        // ##############################
        // overlap and dropped starts
        // ##############################
        wait_idle();
        start_op(OP_SUB, rand_word(), rand_word());
        repeat (15) @(posedge clk);
        start_op(OP_ADD, rand_word(), rand_word()); // sampled on the first idle edge.
        wait_done();
        wait_done();

        wait_idle();
        start_op(OP_AND, rand_word(), rand_word());
        repeat (4) @(posedge clk);
        start_op(OP_OR, rand_word(), rand_word());  // lands mid run and is dropped.
        repeat (8) @(posedge clk);
        start_op(OP_NOR, rand_word(), rand_word()); // lands on the last busy cycle.
        wait_done();
        repeat (25) @(negedge clk);

        total = errors + i_alu16_top.i_alu16_sva.fail_count;
        $display("closing: testbench errors %0d, assertion failures %0d",
            errors, i_alu16_top.i_alu16_sva.fail_count);
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/alu16_pkg.sv
hdl/operand_loader.sv
hdl/serial_alu.sv
hdl/result_collector.sv
hdl/alu16_top.sv
testbench/alu16_sva.sv
testbench/alu16_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the ALU regression with Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module alu16_tb \
    --Mdir obj_dir -o alu16_sim -f verilog.f || exit 1
./obj_dir/alu16_sim +verilator+error+limit+1000 > "$LOG" 2>&1
cat "$LOG"
grep -q "Regression failed" "$LOG" && echo "run_sim: failures reported" && exit 1
grep -q "Regression passed" "$LOG" || { echo "run_sim: run ended early"; exit 1; }
exit 0
